// File: hdl/demodPkg.sv
package demodPkg;

    // Signed error sample width on the datapath side
    localparam int SampleWidth = 16;

    // Byte offsets from the register block base
    localparam logic [11:0] RegCtrlOfs   = 12'h000;
    localparam logic [11:0] RegDacSelOfs = 12'h004;
    localparam logic [11:0] RegLockOfs   = 12'h008;

    typedef enum logic [2:0] {
        ModeAm,
        ModeFm,
        ModePm,
        ModeBpsk,
        ModeQpsk,
        ModeOqpsk,
        ModeFsk,
        ModeIdle
    } demodModeT;

    typedef enum logic [1:0] {
        SyncNrzL,
        SyncNrzM,
        SyncBiphase,
        SyncOff
    } bitsyncModeT;

    // Probe sources where codes 5..15 give mid-scale
    typedef enum logic [3:0] {
        SrcFreqError  = 4'd0,
        SrcPhaseError = 4'd1,
        SrcMagnitude  = 4'd2,
        SrcLockAvg    = 4'd3,
        SrcThreshold  = 4'd4
    } dacSourceT;

endpackage

// File: hdl/regBusIf.sv
`timescale 1ns/1ps

interface regBusIf;

    logic [11:0] addr;
    logic [31:0] dataIn;
    logic [31:0] dataOut;
    logic        cs;
    logic [3:0]  wr;    // Byte lane strobes

    modport host (
        output addr,
        output dataIn,
        output cs,
        output wr,
        input  dataOut
    );

    modport regs (
        input  addr,
        input  dataIn,
        input  cs,
        input  wr,
        output dataOut
    );

endinterface

// File: hdl/demodRegs.sv
`timescale 1ns/1ps

module demodRegs #(
    parameter logic [11:0] BaseAddr = 12'h100
) (
    input  logic                   clk,
    input  logic                   rstN,
    regBusIf.regs                  bus,
    input  logic                   highFreqOffset,
    output demodPkg::demodModeT    demodMode,
    output demodPkg::bitsyncModeT  bitsyncMode,
    output demodPkg::dacSourceT    dac0Select,
    output demodPkg::dacSourceT    dac1Select,
    output demodPkg::dacSourceT    dac2Select,
    output logic [15:0]            falseLockAlpha,
    output logic [15:0]            falseLockThreshold
);

    localparam logic [11:0] CtrlAddr   = BaseAddr + demodPkg::RegCtrlOfs;
    localparam logic [11:0] DacSelAddr = BaseAddr + demodPkg::RegDacSelOfs;
    localparam logic [11:0] LockAddr   = BaseAddr + demodPkg::RegLockOfs;

    logic ctrlHit;
    logic dacSelHit;
    logic lockHit;

    assign ctrlHit   = bus.cs && (bus.addr == CtrlAddr);
    assign dacSelHit = bus.cs && (bus.addr == DacSelAddr);
    assign lockHit   = bus.cs && (bus.addr == LockAddr);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            demodMode          <= demodPkg::ModeAm;
            bitsyncMode        <= demodPkg::SyncNrzL;
            dac0Select         <= demodPkg::SrcFreqError;
            dac1Select         <= demodPkg::SrcFreqError;
            dac2Select         <= demodPkg::SrcFreqError;
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
        end else begin
            if (ctrlHit) begin
                if (bus.wr[0])
                    demodMode <= demodPkg::demodModeT'(bus.dataIn[2:0]);
                if (bus.wr[2])
                    bitsyncMode <= demodPkg::bitsyncModeT'(bus.dataIn[17:16]);
            end
            if (dacSelHit) begin
                if (bus.wr[0])
                    dac0Select <= demodPkg::dacSourceT'(bus.dataIn[3:0]);
                if (bus.wr[1])
                    dac1Select <= demodPkg::dacSourceT'(bus.dataIn[11:8]);
                if (bus.wr[2])
                    dac2Select <= demodPkg::dacSourceT'(bus.dataIn[19:16]);
            end
            if (lockHit) begin
                if (bus.wr[0])
                    falseLockAlpha[7:0] <= bus.dataIn[7:0];
                if (bus.wr[1])
                    falseLockAlpha[15:8] <= bus.dataIn[15:8];
                if (bus.wr[2])
                    falseLockThreshold[7:0] <= bus.dataIn[23:16];
                if (bus.wr[3])
                    falseLockThreshold[15:8] <= bus.dataIn[31:24];
            end
        end
    end

    // Read back with live status in the control word
    always_comb begin
        bus.dataOut = 32'h0;
        if (bus.cs) begin
            case (bus.addr)
                CtrlAddr:
                    bus.dataOut = {highFreqOffset, 13'h0, bitsyncMode, 13'h0, demodMode};
                DacSelAddr:
                    bus.dataOut = {12'h0, dac2Select, 4'h0, dac1Select, 4'h0, dac0Select};
                LockAddr:
                    bus.dataOut = {falseLockThreshold, falseLockAlpha};
                default:
                    bus.dataOut = 32'h0;
            endcase
        end
    end

endmodule

// File: hdl/falseLockDetector.sv
`timescale 1ns/1ps

module falseLockDetector (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 sampleValid,
    input  logic signed [demodPkg::SampleWidth-1:0] freqError,
    input  logic [15:0]                          falseLockAlpha,
    input  logic [15:0]                          falseLockThreshold,
    output logic [15:0]                          magnitude,
    output logic [15:0]                          lockAvg,
    output logic                                 highFreqOffset
);

    logic signed [31:0] avgDiff;
    logic signed [31:0] avgProduct;
    logic signed [31:0] avgNext;

    // Absolute value that clips the most negative code to full scale
    always_comb begin
        if (freqError == 16'sh8000)
            magnitude = 16'h7fff;
        else if (freqError < 0)
            magnitude = 16'(-freqError);
        else
            magnitude = 16'(freqError);
    end

    // avg += ((mag - avg) * alpha) >>> 16
    always_comb begin
        avgDiff    = $signed({16'h0, magnitude}) - $signed({16'h0, lockAvg});
        avgProduct = avgDiff * $signed({16'h0, falseLockAlpha});  // Fits in 32 bits
        avgNext    = $signed({16'h0, lockAvg}) + (avgProduct >>> 16);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lockAvg <= '0;
        end else if (sampleValid) begin
            lockAvg <= avgNext[15:0];
        end
    end

    // Flag trails the average by one clock
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            highFreqOffset <= 1'b0;
        end else begin
            highFreqOffset <= lockAvg > falseLockThreshold;
        end
    end

endmodule

// File: hdl/dacSelector.sv
`timescale 1ns/1ps

module dacSelector (
    input  logic                clk,
    input  logic                rstN,
    input  demodPkg::dacSourceT dac0Select,
    input  demodPkg::dacSourceT dac1Select,
    input  demodPkg::dacSourceT dac2Select,
    input  logic signed [15:0]  freqError,
    input  logic signed [15:0]  phaseError,
    input  logic [15:0]         magnitude,
    input  logic [15:0]         lockAvg,
    input  logic [15:0]         falseLockThreshold,
    output logic [15:0]         dac0,
    output logic [15:0]         dac1,
    output logic [15:0]         dac2
);

    // Source mux followed by two's complement to offset binary
    function automatic logic [15:0] probeCode(input demodPkg::dacSourceT sel);
        logic [15:0] src;
        case (sel)
            demodPkg::SrcFreqError:  src = freqError;
            demodPkg::SrcPhaseError: src = phaseError;
            demodPkg::SrcMagnitude:  src = magnitude;
            demodPkg::SrcLockAvg:    src = lockAvg;
            demodPkg::SrcThreshold:  src = falseLockThreshold;
            default:                 src = 16'h0;   // Mid-scale
        endcase
        return {~src[15], src[14:0]};
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dac0 <= 16'h8000;
            dac1 <= 16'h8000;
            dac2 <= 16'h8000;
        end else begin
            dac0 <= probeCode(dac0Select);
            dac1 <= probeCode(dac1Select);
            dac2 <= probeCode(dac2Select);
        end
    end

endmodule

// File: hdl/demodTop.sv
`timescale 1ns/1ps

module demodTop #(
    parameter logic [11:0] BaseAddr = 12'h100
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic [11:0]                          addr,
    input  logic [31:0]                          dataIn,
    output logic [31:0]                          dataOut,
    input  logic                                 cs,
    input  logic                                 wr0,
    input  logic                                 wr1,
    input  logic                                 wr2,
    input  logic                                 wr3,
    input  logic                                 sampleValid,
    input  logic signed [demodPkg::SampleWidth-1:0] freqError,
    input  logic signed [demodPkg::SampleWidth-1:0] phaseError,
    output demodPkg::demodModeT                  demodMode,
    output demodPkg::bitsyncModeT                bitsyncMode,
    output logic                                 highFreqOffset,
    output logic [15:0]                          dac0,
    output logic [15:0]                          dac1,
    output logic [15:0]                          dac2
);

    demodPkg::dacSourceT dac0Select;
    demodPkg::dacSourceT dac1Select;
    demodPkg::dacSourceT dac2Select;
    logic [15:0]         falseLockAlpha;
    logic [15:0]         falseLockThreshold;
    logic [15:0]         magnitude;
    logic [15:0]         lockAvg;

    regBusIf bus ();

    // Host side of the register bus
    assign bus.addr   = addr;
    assign bus.dataIn = dataIn;
    assign bus.cs     = cs;
    assign bus.wr     = {wr3, wr2, wr1, wr0};
    assign dataOut    = bus.dataOut;

    demodRegs #(
        .BaseAddr(BaseAddr)
    ) u_demodRegs (
        .clk               (clk),
        .rstN              (rstN),
        .bus               (bus),
        .highFreqOffset    (highFreqOffset),
        .demodMode         (demodMode),
        .bitsyncMode       (bitsyncMode),
        .dac0Select        (dac0Select),
        .dac1Select        (dac1Select),
        .dac2Select        (dac2Select),
        .falseLockAlpha    (falseLockAlpha),
        .falseLockThreshold(falseLockThreshold)
    );

    falseLockDetector u_falseLockDetector (
        .clk               (clk),
        .rstN              (rstN),
        .sampleValid       (sampleValid),
        .freqError         (freqError),
        .falseLockAlpha    (falseLockAlpha),
        .falseLockThreshold(falseLockThreshold),
        .magnitude         (magnitude),
        .lockAvg           (lockAvg),
        .highFreqOffset    (highFreqOffset)
    );

    dacSelector u_dacSelector (
        .clk               (clk),
        .rstN              (rstN),
        .dac0Select        (dac0Select),
        .dac1Select        (dac1Select),
        .dac2Select        (dac2Select),
        .freqError         (freqError),
        .phaseError        (phaseError),
        .magnitude         (magnitude),
        .lockAvg           (lockAvg),
        .falseLockThreshold(falseLockThreshold),
        .dac0              (dac0),
        .dac1              (dac1),
        .dac2              (dac2)
    );

endmodule

// File: tb/demodTop_assert.sv
`timescale 1ns/1ps

module demodTopAssert (
    input logic        clk,
    input logic        rstN,
    input logic        cs,
    input logic        sampleValid,
    input logic        highFreqOffset,
    input logic [48:0] cfgState,
    input logic [3:0]  dac0Select,
    input logic [3:0]  dac1Select,
    input logic [3:0]  dac2Select,
    input logic [15:0] dac0,
    input logic [15:0] dac1,
    input logic [15:0] dac2
);

    logic sawSample;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            sawSample <= 1'b0;
        else if (sampleValid)
            sawSample <= 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rstN) !cs |=> $stable(cfgState))
        else $error("Register changed on a write with cs low");

    // Average still zero before the first sample
    assert property (@(posedge clk) disable iff (!rstN) !sawSample |-> !highFreqOffset)
        else $error("highFreqOffset set before any sample");

    assert property (@(posedge clk) disable iff (!rstN) dac0Select >= 4'd5 |=> dac0 == 16'h8000)
        else $error("dac0 not mid-scale for an unused select");
    assert property (@(posedge clk) disable iff (!rstN) dac1Select >= 4'd5 |=> dac1 == 16'h8000)
        else $error("dac1 not mid-scale for an unused select");
    assert property (@(posedge clk) disable iff (!rstN) dac2Select >= 4'd5 |=> dac2 == 16'h8000)
        else $error("dac2 not mid-scale for an unused select");

endmodule

bind demodTop demodTopAssert u_demodTopAssert (
    .clk           (clk),
    .rstN          (rstN),
    .cs            (cs),
    .sampleValid   (sampleValid),
    .highFreqOffset(highFreqOffset),
    .cfgState      ({demodMode, bitsyncMode, dac0Select, dac1Select, dac2Select,
                     falseLockAlpha, falseLockThreshold}),
    .dac0Select    (dac0Select),
    .dac1Select    (dac1Select),
    .dac2Select    (dac2Select),
    .dac0          (dac0),
    .dac1          (dac1),
    .dac2          (dac2)
);

// File: tb/demodTopTb.sv
`timescale 1ns/1ps

module demodTopTb;

    localparam logic [11:0] BaseAddr  = 12'h100;
    localparam logic [11:0] OtherBase = BaseAddr ^ 12'h200;
    localparam int LaneIters     = 16;
    localparam int NumSamples    = 160;
    localparam int PlannedCycles = 30 + 6 * LaneIters + NumSamples + 80;
    localparam logic [31:0] FieldMask [3] = '{32'h0003_0007, 32'h000f_0f0f, 32'hffff_ffff};
    localparam logic [3:0]  CodeList [8]  = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd9, 4'd15};

    logic clk = 1'b0;
    logic rstN;
    logic [11:0] addr;
    logic [31:0] dataIn;
    logic [31:0] dataOut;
    logic cs;
    logic wr0, wr1, wr2, wr3;
    logic sampleValid;
    logic signed [15:0] freqError;
    logic signed [15:0] phaseError;
    demodPkg::demodModeT   demodMode;
    demodPkg::bitsyncModeT bitsyncMode;
    logic highFreqOffset;
    logic [15:0] dac0, dac1, dac2;

    logic [15:0] lfsrState = 16'd14463;
    logic [31:0] shadow [3];    // Ctrl, DAC select, lock
    logic [15:0] avgRef;        // lockAvg after the last edge
    logic [15:0] prevAvg;       // lockAvg one edge earlier
    int errorCount = 0;
    int checkCount = 0;

    // Expectations for the next rising edge
    logic checkRead = 1'b0;
    logic checkFlag = 1'b0;
    logic checkDac  = 1'b0;
    logic [31:0] expRead;
    logic expFlag;
    logic [15:0] expDac [3];

    demodTop #(.BaseAddr(BaseAddr)) u_demodTop (.*);

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [11:0] regAddr(input logic [11:0] base, input int idx);
        return base + 12'(4 * idx);
    endfunction

    function automatic logic [15:0] refMagnitude(input logic signed [15:0] s);
        if (s == 16'sh8000)
            return 16'h7fff;    // Saturates
        return (s < 0) ? 16'(-s) : 16'(s);
    endfunction

    function automatic logic [15:0] avgStep(input logic [15:0] avg, input logic [15:0] mag,
                                            input logic [15:0] alpha);
        longint diff;
        diff = longint'(mag) - longint'(avg);
        return 16'(longint'(avg) + ((diff * longint'(alpha)) >>> 16));
    endfunction

    function automatic logic [15:0] dacCode(input logic [3:0] sel);
        logic [15:0] src;
        case (sel)
            4'd0: src = freqError;
            4'd1: src = phaseError;
            4'd2: src = refMagnitude(freqError);
            4'd3: src = avgRef;
            4'd4: src = shadow[2][31:16];
            default: src = 16'h0;
        endcase
        return src ^ 16'h8000;  // Offset binary
    endfunction

    function automatic logic [31:0] expectedRead(input logic [11:0] a, input logic c,
                                                 input logic flag);
        if (!c)
            return 32'h0;
        case (a)
            regAddr(BaseAddr, 0): return shadow[0] | {flag, 31'h0};
            regAddr(BaseAddr, 1): return shadow[1];
            regAddr(BaseAddr, 2): return shadow[2];
            default:              return 32'h0;
        endcase
    endfunction

    // Only enabled lanes change and unlisted bits stay zero
    function automatic logic [31:0] applyWrite(input logic [31:0] old, input logic [31:0] d,
                                               input logic [3:0] strb, input logic [31:0] mask);
        logic [31:0] res;
        res = old;
        for (int n = 0; n < 4; n++)
            if (strb[n])
                res[8*n +: 8] = d[8*n +: 8] & mask[8*n +: 8];
        return res;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        errorCount++;
        $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    endtask

    always @(posedge clk) begin
        if (checkRead) begin
            checkCount++;
            if (dataOut !== expRead)
                reportMismatch("dataOut", expRead, dataOut);
            if (demodMode !== shadow[0][2:0])
                reportMismatch("demodMode", shadow[0][2:0], demodMode);
            if (bitsyncMode !== shadow[0][17:16])
                reportMismatch("bitsyncMode", shadow[0][17:16], bitsyncMode);
        end
        if (checkFlag) begin
            checkCount++;
            if (highFreqOffset !== expFlag)
                reportMismatch("highFreqOffset", expFlag, highFreqOffset);
        end
        if (checkDac) begin
            checkCount++;
            if (dac0 !== expDac[0])
                reportMismatch("dac0", expDac[0], dac0);
            if (dac1 !== expDac[1])
                reportMismatch("dac1", expDac[1], dac1);
            if (dac2 !== expDac[2])
                reportMismatch("dac2", expDac[2], dac2);
        end
    end

    task automatic busCycle(input logic [11:0] a, input logic [31:0] d, input logic c,
                            input logic [3:0] strb);
        @(negedge clk);
        addr = a;
        dataIn = d;
        cs = c;
        {wr3, wr2, wr1, wr0} = strb;
        checkRead = 1'b0;
        checkFlag = 1'b0;
        checkDac = 1'b0;
    endtask

    task automatic writeReg(input int r, input logic [31:0] d, input logic [3:0] strb);
        busCycle(regAddr(BaseAddr, r), d, 1'b1, strb);
        shadow[r] = applyWrite(shadow[r], d, strb, FieldMask[r]);
    endtask

    task automatic readReg(input logic [11:0] a, input logic c);
        busCycle(a, 32'h0, c, 4'h0);
        expRead = expectedRead(a, c, avgRef > shadow[2][31:16]);
        checkRead = 1'b1;
    endtask

    // Inputs must have been stable for one cycle already
    task automatic dacCheck();
        busCycle(12'h0, 32'h0, 1'b0, 4'h0);
        expDac[0] = dacCode(shadow[1][3:0]);
        expDac[1] = dacCode(shadow[1][11:8]);
        expDac[2] = dacCode(shadow[1][19:16]);
        checkDac = 1'b1;
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] s;
        rstN = 1'b0;
        addr = '0;
        dataIn = '0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        sampleValid = 1'b0;
        freqError = '0;
        phaseError = '0;
        shadow = '{default: 32'h0};
        avgRef = '0;
        prevAvg = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        expDac[0] = 16'h8000;   // Mid-scale while held in reset
        expDac[1] = 16'h8000;
        expDac[2] = 16'h8000;
        checkDac = 1'b1;
        @(negedge clk);
        checkDac = 1'b0;
        rstN = 1'b1;

        for (int r = 0; r < 3; r++)
            readReg(regAddr(BaseAddr, r), 1'b1);
        dacCheck();

        for (int i = 0; i < LaneIters; i++) begin
            for (int r = 0; r < 3; r++) begin
                drawBits(32, d);
                drawBits(4, s);
                writeReg(r, d, s[3:0]);
                readReg(regAddr(BaseAddr, r), 1'b1);
            end
        end

        // No decode write may land
        for (int r = 0; r < 3; r++) begin
            d = ~shadow[r];
            busCycle(regAddr(BaseAddr, r), d, 1'b0, 4'hf);
            busCycle(regAddr(OtherBase, r), d, 1'b1, 4'hf);
            readReg(regAddr(BaseAddr, r), 1'b0);
            readReg(regAddr(OtherBase, r), 1'b1);
        end
        busCycle(regAddr(BaseAddr, 3), d, 1'b1, 4'hf);
        readReg(regAddr(BaseAddr, 3), 1'b1);
        for (int r = 0; r < 3; r++)
            readReg(regAddr(BaseAddr, r), 1'b1);

        writeReg(2, 32'h3c00_3000, 4'hf);   // Threshold, alpha
        writeReg(1, 32'h0004_0403, 4'h7);   // dac0 on lockAvg and the others on threshold
        busCycle(12'h0, 32'h0, 1'b0, 4'h0);
        for (int k = 0; k < NumSamples; k++) begin
            drawBits(2, s);
            drawBits(16, d);
            busCycle(regAddr(BaseAddr, 0), 32'h0, 1'b1, 4'h0);
            sampleValid = s[0] | s[1];
            freqError = (k < NumSamples / 2) ? d[15:0] : {{5{d[15]}}, d[15:5]};
            if (k == 7) begin
                freqError = 16'h8000;
                sampleValid = 1'b1;
            end
            expFlag = prevAvg > shadow[2][31:16];
            expRead = expectedRead(regAddr(BaseAddr, 0), 1'b1, expFlag);
            expDac[0] = prevAvg ^ 16'h8000;
            expDac[1] = dacCode(4'd4);
            expDac[2] = dacCode(4'd4);
            checkRead = 1'b1;
            checkFlag = 1'b1;
            checkDac = 1'b1;
            prevAvg = avgRef;
            if (sampleValid)
                avgRef = avgStep(avgRef, refMagnitude(freqError), shadow[2][15:0]);
        end
        busCycle(12'h0, 32'h0, 1'b0, 4'h0);
        sampleValid = 1'b0;
        busCycle(12'h0, 32'h0, 1'b0, 4'h0);
        prevAvg = avgRef;

        for (int n = 0; n < 3; n++) begin
            for (int c = 0; c < 8; c++) begin
                drawBits(32, d);
                writeReg(1, {12'h0, CodeList[c], 4'h0, CodeList[c], 4'h0, CodeList[c]},
                         4'(1 << n));
                freqError = (n == 1 && c == 2) ? 16'h8000 : d[15:0];
                phaseError = d[31:16];
                busCycle(12'h0, 32'h0, 1'b0, 4'h0);
                dacCheck();
            end
        end
        readReg(regAddr(BaseAddr, 0), 1'b1);
        busCycle(12'h0, 32'h0, 1'b0, 4'h0);

        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #((PlannedCycles + 100) * 40);
        $display("Timeout: the test sequence did not complete in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: project.f
hdl/demodPkg.sv
hdl/regBusIf.sv
hdl/demodRegs.sv
hdl/falseLockDetector.sv
hdl/dacSelector.sv
hdl/demodTop.sv
tb/demodTop_assert.sv
tb/demodTopTb.sv
